// File: include/aes_macros.svh
// Width, round count and latency constants for the AES-128 encryption pipeline
// Included by the package and by every RTL module of the core
`ifndef AES_MACROS_SVH
`define AES_MACROS_SVH

//////////////////////////////////////////////////
// Data widths in bits
//////////////////////////////////////////////////

`define AES_BLOCK_W 128
`define AES_WORD_W  32
`define AES_BYTE_W  8

//////////////////////////////////////////////////
// Rounds and pipeline depth
//////////////////////////////////////////////////

// Ten rounds for a 128-bit key
`define AES_ROUNDS  10

// Input sample edge to output edge, two cycles per round
`define AES_LATENCY 20

`endif

// File: logic/aes_pkg.sv
// Shared types and GF(2^8) helper functions for the AES-128 pipeline
// Imported by every RTL module; functions are used both for constants and logic
`default_nettype none
`include "aes_macros.svh"

package aes_pkg;

    //////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////

    typedef logic [`AES_BYTE_W-1:0] aes_byte_t;

    // Byte 0 is the most significant byte, i.e. row 0 of the column
    typedef logic [0:`AES_WORD_W/`AES_BYTE_W-1][`AES_BYTE_W-1:0] aes_word_t;

    // Column view of a block, indexed [column][row]
    typedef logic [0:`AES_BLOCK_W/`AES_WORD_W-1][0:`AES_WORD_W/`AES_BYTE_W-1]
        [`AES_BYTE_W-1:0] aes_cols_t;

    // State or key, w0 in the top bits
    typedef struct packed {
        aes_word_t w0;
        aes_word_t w1;
        aes_word_t w2;
        aes_word_t w3;
    } aes_block_t;

    // Block with its strobe
    typedef struct packed {
        logic       valid;
        aes_block_t state;
    } aes_beat_t;

    //////////////////////////////////////////////////
    // Field arithmetic
    //////////////////////////////////////////////////

    // Multiply by x modulo x^8 + x^4 + x^3 + x + 1
    function automatic aes_byte_t aes_xtime(aes_byte_t b);
        return {b[`AES_BYTE_W-2:0], 1'b0} ^ (b[`AES_BYTE_W-1] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic aes_byte_t aes_gf_mul(aes_byte_t a, aes_byte_t b);
        aes_byte_t acc;
        aes_byte_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < `AES_BYTE_W; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = aes_xtime(sh);
        end
        return acc;
    endfunction

    // Field inverse followed by the affine map
    function automatic aes_byte_t aes_sbox(aes_byte_t b);
        aes_byte_t                sq;
        aes_byte_t                inv;
        aes_byte_t                res;
        logic [2*`AES_BYTE_W-1:0] dbl;
        sq  = b;
        inv = 8'h01;
        // Accumulates b^254, which is the inverse and maps zero to zero
        for (int i = 1; i < `AES_BYTE_W; i++) begin
            sq  = aes_gf_mul(sq, sq);
            inv = aes_gf_mul(inv, sq);
        end
        // XOR of the inverse with its left rotations by 1 to 4
        res = 8'h63;
        for (int i = 0; i < 5; i++) begin
            dbl = {inv, inv} >> (`AES_BYTE_W - i);
            res = res ^ dbl[`AES_BYTE_W-1:0];
        end
        return res;
    endfunction

    // Round constant for key expansion round 1 to 10
    function automatic aes_byte_t aes_rcon(int round_idx);
        aes_byte_t rc;
        rc = 8'h01;
        for (int i = 2; i <= `AES_ROUNDS; i++) begin
            if (i <= round_idx) begin
                rc = aes_xtime(rc);
            end
        end
        return rc;
    endfunction

    function automatic aes_word_t aes_sub_word(aes_word_t w);
        aes_word_t s;
        for (int i = 0; i < `AES_WORD_W / `AES_BYTE_W; i++) begin
            s[i] = aes_sbox(w[i]);
        end
        return s;
    endfunction

endpackage

`default_nettype wire

// File: logic/aes_key_stage.sv
// One AES-128 key expansion stage, two cycles deep
// round_key is ready one cycle after key_in, next_key one cycle later
`timescale 1ns/1ps
`default_nettype none
`include "aes_macros.svh"

module aes_key_stage
    import aes_pkg::*;
#(
    parameter int ROUND_INDEX = 1
) (
    input  logic       clk,
    input  aes_block_t key_in,
    output aes_block_t round_key,
    output aes_block_t next_key
);

    localparam int        NCOL = `AES_BLOCK_W / `AES_WORD_W;
    localparam aes_byte_t RCON = aes_rcon(ROUND_INDEX);

    aes_cols_t key_cols;
    aes_cols_t acc_d;
    aes_cols_t acc_q;
    aes_cols_t rk_cols;
    aes_word_t rot_word;
    aes_word_t sub_q;

    assign key_cols = key_in;

    // Running XOR of the words, with rcon folded into the first
    always_comb begin
        acc_d[0] = key_cols[0] ^ {RCON, {(`AES_WORD_W - `AES_BYTE_W){1'b0}}};
        for (int i = 1; i < NCOL; i++) begin
            acc_d[i] = acc_d[i-1] ^ key_cols[i];
        end
    end

    // RotWord of the last word
    assign rot_word = {key_cols[NCOL-1][1], key_cols[NCOL-1][2],
                       key_cols[NCOL-1][3], key_cols[NCOL-1][0]};

    always_ff @(posedge clk) begin
        acc_q <= acc_d;
        sub_q <= aes_sub_word(rot_word);
    end

    // Every word picks up the same substituted term
    always_comb begin
        for (int i = 0; i < NCOL; i++) begin
            rk_cols[i] = acc_q[i] ^ sub_q;
        end
    end

    assign round_key = rk_cols;

    always_ff @(posedge clk) begin
        next_key <= round_key;
    end

endmodule

`default_nettype wire

// File: logic/aes_round.sv
// One AES middle round, two cycles deep
// Cycle 1 registers S and 2*S per byte; cycle 2 mixes columns and adds the key
`timescale 1ns/1ps
`default_nettype none
`include "aes_macros.svh"

module aes_round
    import aes_pkg::*;
(
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    localparam int NCOL = `AES_BLOCK_W / `AES_WORD_W;
    localparam int NROW = `AES_WORD_W / `AES_BYTE_W;

    aes_cols_t in_cols;
    aes_cols_t key_cols;
    aes_cols_t sb_d;
    aes_cols_t xsb_d;
    aes_cols_t sb_q;
    aes_cols_t xsb_q;
    aes_cols_t mix_d;

    assign in_cols  = state_in;
    assign key_cols = round_key;

    //////////////////////////////////////////////////
    // Table lookup stage
    //////////////////////////////////////////////////

    always_comb begin
        for (int c = 0; c < NCOL; c++) begin
            for (int j = 0; j < NROW; j++) begin
                sb_d[c][j]  = aes_sbox(in_cols[c][j]);
                xsb_d[c][j] = aes_xtime(sb_d[c][j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        sb_q  <= sb_d;
        xsb_q <= xsb_d;
    end

    //////////////////////////////////////////////////
    // ShiftRows, MixColumns and key add
    //////////////////////////////////////////////////

    always_comb begin
        aes_word_t te;
        int        src;
        mix_d = key_cols;
        for (int c = 0; c < NCOL; c++) begin
            for (int j = 0; j < NROW; j++) begin
                // Row j of output column c comes from column c+j
                src = (c + j) % NCOL;
                // Entry for row 0 is {2S, S, S, 3S}
                te = {xsb_q[src][j], sb_q[src][j], sb_q[src][j],
                      sb_q[src][j] ^ xsb_q[src][j]};
                // Lower rows use the same entry rotated down by j bytes
                for (int r = 0; r < NROW; r++) begin
                    mix_d[c][r] = mix_d[c][r] ^ te[(r + NROW - j) % NROW];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        state_out <= mix_d;
    end

endmodule

`default_nettype wire

// File: logic/aes_final_round.sv
// Last AES round without MixColumns, two cycles deep
// Cycle 1 registers the S-box bytes; cycle 2 shifts rows and adds the key
`timescale 1ns/1ps
`default_nettype none
`include "aes_macros.svh"

module aes_final_round
    import aes_pkg::*;
(
    input  logic       clk,
    input  aes_block_t state_in,
    input  aes_block_t round_key,
    output aes_block_t state_out
);

    localparam int NCOL = `AES_BLOCK_W / `AES_WORD_W;
    localparam int NROW = `AES_WORD_W / `AES_BYTE_W;

    aes_cols_t in_cols;
    aes_cols_t key_cols;
    aes_cols_t sb_d;
    aes_cols_t sb_q;
    aes_cols_t shift_d;

    assign in_cols  = state_in;
    assign key_cols = round_key;

    always_comb begin
        for (int c = 0; c < NCOL; c++) begin
            for (int j = 0; j < NROW; j++) begin
                sb_d[c][j] = aes_sbox(in_cols[c][j]);
            end
        end
    end

    always_ff @(posedge clk) begin
        sb_q <= sb_d;
    end

    // Row r is rotated left by r columns
    always_comb begin
        for (int c = 0; c < NCOL; c++) begin
            for (int r = 0; r < NROW; r++) begin
                shift_d[c][r] = sb_q[(c + r) % NCOL][r] ^ key_cols[c][r];
            end
        end
    end

    always_ff @(posedge clk) begin
        state_out <= shift_d;
    end

endmodule

`default_nettype wire

// File: logic/aes_core.sv
// Fully pipelined AES-128 encryptor, one block and key per cycle
// Ciphertext and its strobe appear AES_LATENCY cycles after the input edge
`timescale 1ns/1ps
`default_nettype none
`include "aes_macros.svh"

module aes_core
    import aes_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  aes_beat_t  in,
    input  aes_block_t key,
    output aes_beat_t  out
);

    aes_block_t            white_q;
    aes_block_t            key_q;
    logic [`AES_LATENCY:0] vld_q;
    aes_block_t            key_chain   [0:`AES_ROUNDS-1];
    aes_block_t            round_keys  [1:`AES_ROUNDS];
    aes_block_t            state_chain [0:`AES_ROUNDS-1];
    aes_block_t            cipher;

    //////////////////////////////////////////////////
    // Input whitening and strobe delay
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        white_q <= in.state ^ key;
        key_q   <= key;
    end

    // Stage 0 samples with the whitening, stage AES_LATENCY drives out
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[`AES_LATENCY-1:0], in.valid};
        end
    end

    assign key_chain[0]   = key_q;
    assign state_chain[0] = white_q;

    //////////////////////////////////////////////////
    // Key chain
    //////////////////////////////////////////////////

    for (genvar r = 1; r <= `AES_ROUNDS; r++) begin : g_key
        if (r < `AES_ROUNDS) begin : g_mid
            aes_key_stage #(.ROUND_INDEX(r)) u_key (
                .clk       (clk),
                .key_in    (key_chain[r-1]),
                .round_key (round_keys[r]),
                .next_key  (key_chain[r])
            );
        end else begin : g_last
            // No round follows, so the forwarded key is left open
            aes_key_stage #(.ROUND_INDEX(r)) u_key (
                .clk       (clk),
                .key_in    (key_chain[r-1]),
                .round_key (round_keys[r]),
                .next_key  ()
            );
        end
    end

    //////////////////////////////////////////////////
    // Round chain
    //////////////////////////////////////////////////

    for (genvar r = 1; r < `AES_ROUNDS; r++) begin : g_round
        aes_round u_round (
            .clk       (clk),
            .state_in  (state_chain[r-1]),
            .round_key (round_keys[r]),
            .state_out (state_chain[r])
        );
    end

    aes_final_round u_final (
        .clk       (clk),
        .state_in  (state_chain[`AES_ROUNDS-1]),
        .round_key (round_keys[`AES_ROUNDS]),
        .state_out (cipher)
    );

    assign out = '{valid: vld_q[`AES_LATENCY], state: cipher};

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Free-running testbench clock, starts low
// Period is twice HALF_PERIOD in ns, 100 ns by default
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int HALF_PERIOD = 50
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #HALF_PERIOD clk = ~clk;
    end

endmodule

`default_nettype wire

// File: tb/aes_tb.sv
// Self-checking testbench for the pipelined AES-128 core
// Drives known and random blocks on the falling edge and checks against a byte-wise model
`timescale 1ns/1ps
`default_nettype none
`include "aes_macros.svh"

module aes_tb
    import aes_pkg::*;
();

    localparam int LAT         = `AES_LATENCY;
    localparam int DRAIN_LIMIT = `AES_LATENCY + 10;

    logic         clk;
    logic         rst;
    aes_beat_t    in_beat;
    aes_block_t   key_blk;
    aes_beat_t    out_beat;
    logic [7:0]   sbox_tbl [0:255];
    logic [31:0]  rng_state;
    logic [127:0] exp_q [$];
    bit           vld_hist [$];
    int           value_errors;
    int           other_errors;
    int           checked;
    int           sent;

    tb_clock #(.HALF_PERIOD(50)) u_clk (.clk(clk));

    aes_core UUT (
        .clk (clk),
        .rst (rst),
        .in  (in_beat),
        .key (key_blk),
        .out (out_beat)
    );

    //////////////////////////////////////////////////
    // Random numbers
    //////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic logic [127:0] rand_block();
        logic [127:0] b;
        for (int i = 0; i < 4; i++) begin
            b[127-32*i -: 32] = rand_word();
        end
        return b;
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [7:0] times_two(logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // p walks the field by multiplying by 3, q tracks its inverse
    task automatic build_sbox();
        logic [7:0] p;
        logic [7:0] q;
        logic [7:0] x;
        p = 8'h01;
        q = 8'h01;
        for (int i = 0; i < 255; i++) begin
            p = p ^ times_two(p);
            q = q ^ (q << 1);
            q = q ^ (q << 2);
            q = q ^ (q << 4);
            if (q[7]) begin
                q = q ^ 8'h09;
            end
            x = q ^ {q[6:0], q[7]} ^ {q[5:0], q[7:6]} ^ {q[4:0], q[7:5]} ^ {q[3:0], q[7:4]};
            sbox_tbl[p] = x ^ 8'h63;
        end
        sbox_tbl[0] = 8'h63;
    endtask

    function automatic logic [31:0] sub_rot(logic [31:0] w);
        return {sbox_tbl[w[23:16]], sbox_tbl[w[15:8]], sbox_tbl[w[7:0]], sbox_tbl[w[31:24]]};
    endfunction

    function automatic logic [127:0] encrypt_model(logic [127:0] pt, logic [127:0] k);
        logic [31:0]  w [0:43];
        logic [7:0]   st [0:15];
        logic [7:0]   tmp [0:15];
        logic [7:0]   rc;
        logic [7:0]   a0;
        logic [7:0]   a1;
        logic [7:0]   a2;
        logic [7:0]   a3;
        logic [127:0] res;
        rc = 8'h01;
        for (int i = 0; i < 4; i++) begin
            w[i] = k[127-32*i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
            if (i % 4 == 0) begin
                w[i] = w[i-4] ^ sub_rot(w[i-1]) ^ {rc, 24'h0};
                rc = times_two(rc);
            end else begin
                w[i] = w[i-4] ^ w[i-1];
            end
        end
        for (int i = 0; i < 16; i++) begin
            st[i] = pt[127-8*i -: 8] ^ w[i/4][31-8*(i%4) -: 8];
        end
        for (int r = 1; r <= 10; r++) begin
            // SubBytes and ShiftRows in one pass
            for (int c = 0; c < 4; c++) begin
                for (int row = 0; row < 4; row++) begin
                    tmp[4*c+row] = sbox_tbl[st[4*((c+row)%4)+row]];
                end
            end
            for (int c = 0; c < 4; c++) begin
                a0 = tmp[4*c];
                a1 = tmp[4*c+1];
                a2 = tmp[4*c+2];
                a3 = tmp[4*c+3];
                if (r < 10) begin
                    st[4*c]   = times_two(a0) ^ times_two(a1) ^ a1 ^ a2 ^ a3;
                    st[4*c+1] = a0 ^ times_two(a1) ^ times_two(a2) ^ a2 ^ a3;
                    st[4*c+2] = a0 ^ a1 ^ times_two(a2) ^ times_two(a3) ^ a3;
                    st[4*c+3] = times_two(a0) ^ a0 ^ a1 ^ a2 ^ times_two(a3);
                end else begin
                    st[4*c]   = a0;
                    st[4*c+1] = a1;
                    st[4*c+2] = a2;
                    st[4*c+3] = a3;
                end
            end
            for (int i = 0; i < 16; i++) begin
                st[i] = st[i] ^ w[4*r + i/4][31-8*(i%4) -: 8];
            end
        end
        for (int i = 0; i < 16; i++) begin
            res[127-8*i -: 8] = st[i];
        end
        return res;
    endfunction

    //////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////

    // Outputs only move on the rising edge, so the falling edge sees them settled
    task automatic check_outputs();
        bit           exp_v;
        logic [127:0] exp_data;
        exp_v = vld_hist.pop_front();
        if (out_beat.valid !== exp_v) begin
            $display("FAILED at %0t: out.valid expected %0b got %0b",
                     $time, exp_v, out_beat.valid);
            value_errors++;
        end
        // Each strobe from the core takes the oldest expected block
        if (out_beat.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected output block at %0t with no block left to expect",
                         $time);
                other_errors++;
            end else begin
                exp_data = exp_q.pop_front();
                checked++;
                if (out_beat.state !== exp_data) begin
                    $display("FAILED at %0t: out.state expected %032h got %032h",
                             $time, exp_data, out_beat.state);
                    value_errors++;
                end
            end
        end
    endtask

    task automatic apply_inputs(logic rst_v, logic valid_v, logic [127:0] pt, logic [127:0] k);
        rst           = rst_v;
        in_beat.valid = valid_v;
        in_beat.state = pt;
        key_blk       = k;
        vld_hist.push_back(valid_v && !rst_v);
        if (valid_v && !rst_v) begin
            exp_q.push_back(encrypt_model(pt, k));
            sent++;
        end
    endtask

    task automatic drive_cycle(logic rst_v, logic valid_v, logic [127:0] pt, logic [127:0] k);
        @(negedge clk);
        check_outputs();
        apply_inputs(rst_v, valid_v, pt, k);
    endtask

    task automatic send_known(logic [127:0] pt, logic [127:0] k, logic [127:0] ct);
        if (encrypt_model(pt, k) !== ct) begin
            $display("Reference model disagrees with the FIPS-197 vector for key %032h", k);
            other_errors++;
        end
        drive_cycle(1'b0, 1'b1, pt, k);
    endtask

    task automatic idle_cycle();
        logic [127:0] pt;
        logic [127:0] k;
        pt = rand_block();
        k  = rand_block();
        drive_cycle(1'b0, 1'b0, pt, k);
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic         valid_v;
        logic [127:0] pt;
        logic [127:0] k;
        int           drain_cycles;
        value_errors = 0;
        other_errors = 0;
        checked      = 0;
        sent         = 0;
        rng_state    = 32'd25840;
        build_sbox();
        // Outputs before the first valid input can reach the end are all idle
        for (int i = 0; i < LAT; i++) begin
            vld_hist.push_back(1'b0);
        end
        // Valid held high during reset must never reach the output
        apply_inputs(1'b1, 1'b1, '0, '0);

        // Reset spans the first 10 rising edges
        for (int i = 1; i < 10; i++) begin
            drive_cycle(1'b1, 1'b1, '0, '0);
        end
        for (int i = 0; i < LAT; i++) begin
            idle_cycle();
        end

        send_known(128'h3243f6a8885a308d313198a2e0370734,
                   128'h2b7e151628aed2a6abf7158809cf4f3c,
                   128'h3925841d02dc09fbdc118597196a0b32);
        send_known(128'h00112233445566778899aabbccddeeff,
                   128'h000102030405060708090a0b0c0d0e0f,
                   128'h69c4e0d86a7b0430d8cdb78070b4c55a);
        idle_cycle();

        // Back-to-back blocks
        for (int i = 0; i < 200; i++) begin
            pt = rand_block();
            k  = rand_block();
            drive_cycle(1'b0, 1'b1, pt, k);
        end

        // Random gaps, about one idle cycle in three
        for (int i = 0; i < 200; i++) begin
            valid_v = (rand_word() % 3) != 0;
            pt      = rand_block();
            k       = rand_block();
            drive_cycle(1'b0, valid_v, pt, k);
        end

        drain_cycles = 0;
        while (exp_q.size() > 0 && drain_cycles < DRAIN_LIMIT) begin
            idle_cycle();
            drain_cycles++;
        end
        if (exp_q.size() > 0) begin
            $display("Timed out draining the pipeline with %0d blocks still expected",
                     exp_q.size());
            other_errors++;
        end

        // Quiet tail catches late or extra strobes
        for (int i = 0; i < LAT + 5; i++) begin
            idle_cycle();
        end
        if (checked != sent) begin
            $display("Sent %0d blocks but only %0d came out", sent, checked);
            other_errors++;
        end

        $display("Checked %0d of %0d blocks: %0d value errors, %0d other errors",
                 checked, sent, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
logic/aes_pkg.sv
logic/aes_key_stage.sv
logic/aes_round.sv
logic/aes_final_round.sv
logic/aes_core.sv
tb/tb_clock.sv
tb/aes_tb.sv

// File: Bender.yml
package:
  name: aes_pipe

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/aes_pkg.sv
      - logic/aes_key_stage.sv
      - logic/aes_round.sv
      - logic/aes_final_round.sv
      - logic/aes_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_clock.sv
      - tb/aes_tb.sv
